// ==== dv/ni_trace.txt ====
# cmd a b c in hex. T name | W/R reg data | P word_addr base n | M byte_addr base n
# I/S hdr base n: inject/expect header then n words base+k | H/U credits | C n | Q irq | K irq
T reset_regs
R 0 0
K 0
W 1 3
R 1 3
W 2 40
R 2 40
W 4 a7
R 4 a7
W 9 200
R 9 200
W b 8
R b 8
T send
P 10 11110000 4
W 0 4
W 3 4
S a753 11110000 4
Q
R 0 24
W 0 e0
K 0
T credit_hold
P 20 22220000 a
W 2 80
W 0 4
H
W 3 a
C 8
U
S a753 22220000 a
Q
R 0 24
W 0 e0
T receive
W 0 8
W d 1
I 3c65 33330000 3
Q
M 200 33330000 3
R 8 3c000006
R a c
R 0 48
W 0 e0
T overflow
W 9 300
W b 3
W 0 8
W d 1
I 4271 44440000 5
Q
M 300 44440000 3
M 30c dead00c3 1
R a 14
R 0 2c8
W 0 3e0
T size_error
W 0 10
W 3 0
Q
C 0
R 0 190
W 0 3e0
T concurrent
P 30 55550000 3
W 2 c0
W 9 100
W b 8
W d 1
W 0 8
W 3 3
I 1e25 66660000 2
S a753 55550000 3
Q
W 0 4
Q
R 0 64
M 100 66660000 2
R 8 1e000002
R a 8
W 0 3e0

// ==== tb.f ====
hdl/ni_pkg.sv
hdl/ni_send_dma.sv
hdl/ni_receive_dma.sv
hdl/ni_regs.sv
hdl/ni_top.sv
dv/ni_tb.sv

// ==== Bender.yml ====
package:
  name: ni_dma

sources:
  - hdl/ni_pkg.sv
  - hdl/ni_send_dma.sv
  - hdl/ni_receive_dma.sv
  - hdl/ni_regs.sv
  - hdl/ni_top.sv
  - target: test
    files:
      - dv/ni_tb.sv

// ==== dv/ni_tb.sv ====
`timescale 1ns/1ps
/* testbench for ni_top with clock and reset, memory and router models,
   trace interpreter and register, flit and memory checks */
module ni_tb;
    import ni_pkg::*;

    localparam int     LB      = 8;
    localparam int     TIMEOUT = 400;    // cycles allowed per wait
    localparam eaddr_t MY_ADDR = 4'h5;

    logic      clk;
    logic      reset;
    logic      s_stb_i;
    logic      s_we_i;
    reg_addr_t s_addr_i;
    data_t     s_dat_i;
    data_t     s_dat_o;
    logic      s_ack_o;
    logic      m_send_stb_o;
    data_t     m_send_addr_o;
    data_t     m_send_dat_i;
    logic      m_send_ack_i;
    logic      m_rcv_stb_o;
    data_t     m_rcv_addr_o;
    data_t     m_rcv_dat_o;
    logic      m_rcv_ack_i;
    flit_t     flit_o;
    logic      flit_wr_o;
    logic      credit_i;
    flit_t     flit_i;
    logic      flit_wr_i;
    logic      credit_o;
    eaddr_t    current_e_addr_i;
    logic      irq_o;

    data_t mem [256];
    flit_t sent_q [$];       // flits that left the DUT in order
    int    outstanding;      // flits at the router not yet credited back
    logic  credit_due;
    logic  hold;
    int    in_credits;       // free slots in the DUT flit FIFO
    int    send_wait;
    int    rcv_wait;
    int    errors;           // errors of the running test
    int    total_errors;
    int    tests;
    int    failed_tests;
    logic  aborted;
    string test_name;

    ni_top #(.LB(LB)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // router model samples mid-cycle where DUT outputs are settled
    always @(negedge clk) begin
        if (flit_wr_o) begin
            sent_q.push_back(flit_o);
            outstanding++;
            assert (outstanding <= LB) else begin
                $display("%s: router holds %0d flits, more than LB", test_name, outstanding);
                errors++;
            end
        end
        credit_due = 1'b0;
        if (!reset && !hold && outstanding > 0 && ($urandom % 3) == 0) begin
            credit_due = 1'b1;
            outstanding--;
        end
        if (credit_o) begin
            in_credits++;
            assert (in_credits <= LB) else begin
                $display("%s: DUT returned a credit for a flit it never took", test_name);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        #2;
        credit_i = credit_due;
    end

    // both masters get single-cycle acks after 0 to 3 wait cycles
    always @(posedge clk) begin
        #2;
        if (m_send_ack_i) begin
            m_send_ack_i = 1'b0;
        end else if (m_send_stb_o) begin
            if (send_wait == 0) begin
                m_send_dat_i = mem[m_send_addr_o[9:2]];
                m_send_ack_i = 1'b1;
                send_wait    = $urandom % 4;
            end else begin
                send_wait--;
            end
        end
        if (m_rcv_ack_i) begin
            m_rcv_ack_i = 1'b0;
        end else if (m_rcv_stb_o) begin
            if (rcv_wait == 0) begin
                mem[m_rcv_addr_o[9:2]] = m_rcv_dat_o;
                m_rcv_ack_i = 1'b1;
                rcv_wait    = $urandom % 4;
            end else begin
                rcv_wait--;
            end
        end
    end

    task automatic step_cycle;
        @(posedge clk);
        #2;
    endtask

    task automatic abort_run(input string what);
        $display("%s: %s", test_name, what);
        errors++;
        aborted = 1'b1;
    endtask

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] got);
        assert (got === exp) else begin
            $display("FAIL %s %s: expected %0h, got %0h", test_name, what, exp, got);
            errors++;
        end
    endtask

    // k = 0 is the header and the last payload word is flagged tail
    function automatic flit_t packet_flit(input data_t hdr, input data_t base, input int n,
                                          input int k);
        if (k == 0) return {HDR_FLIT, hdr};
        if (k == n) return {TAIL_FLIT, data_t'(base + k - 1)};
        return {BODY_FLIT, data_t'(base + k - 1)};
    endfunction

    task automatic reg_access(input logic we, input reg_addr_t addr, input data_t wdata,
                              output data_t rdata);
        int t;
        t        = 0;
        s_stb_i  = 1'b1;
        s_we_i   = we;
        s_addr_i = addr;
        s_dat_i  = wdata;
        @(negedge clk);
        while (!s_ack_o && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        rdata = s_dat_o;          // valid with ack
        assert (s_ack_o) else abort_run($sformatf("register %0h never acked", addr));
        step_cycle();
        s_stb_i = 1'b0;
        s_we_i  = 1'b0;
    endtask

    task automatic inject_packet(input data_t hdr, input data_t base, input int n);
        int k;
        int t;
        for (k = 0; k <= n && !aborted; k++) begin
            t = 0;
            while (in_credits == 0 && t < TIMEOUT) begin
                step_cycle();
                t++;
            end
            assert (in_credits > 0) else abort_run("DUT returned no credit for an inbound flit");
            if (!aborted) begin
                in_credits--;
                flit_i    = packet_flit(hdr, base, n, k);
                flit_wr_i = 1'b1;
                step_cycle();
                flit_wr_i = 1'b0;
            end
        end
    endtask

    task automatic expect_packet(input data_t hdr, input data_t base, input int n);
        int    k;
        int    t;
        flit_t got;
        for (k = 0; k <= n && !aborted; k++) begin
            t = 0;
            while (sent_q.size() == 0 && t < TIMEOUT) begin
                step_cycle();
                t++;
            end
            assert (sent_q.size() > 0) else abort_run("expected flit never reached the router");
            if (!aborted) begin
                got = sent_q.pop_front();
                check_value($sformatf("flit %0d", k), packet_flit(hdr, base, n, k), got);
            end
        end
    endtask

    // n flits arrive and nothing follows for a while
    task automatic expect_held(input int n);
        int t;
        t = 0;
        while (sent_q.size() < n && t < TIMEOUT) begin
            step_cycle();
            t++;
        end
        repeat (20) step_cycle();
        check_value("flits at the router", n, sent_q.size());
    endtask

    task automatic hold_credits;
        int t;
        t = 0;
        while (outstanding != 0 && t < TIMEOUT) begin
            step_cycle();
            t++;
        end
        assert (outstanding == 0) else abort_run("router never drained before the hold");
        hold = 1'b1;
    endtask

    task automatic wait_irq;
        int t;
        t = 0;
        @(negedge clk);
        while (!irq_o && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        assert (irq_o) else abort_run("irq_o never rose");
        step_cycle();
    endtask

    task automatic close_test;
        if (test_name != "") begin
            tests++;
            if (errors == 0) begin
                $display("test %s: ok", test_name);
            end else begin
                $display("test %s: %0d errors", test_name, errors);
                failed_tests++;
            end
        end
        total_errors += errors;
        errors = 0;
    endtask

    initial begin
        int    fd;
        int    i;
        int    n;
        int    rnd;
        string line;
        string name;
        byte   cmd;
        data_t a;
        data_t b;
        data_t c;
        data_t rd;
        rnd              = $urandom(12544);
        reset            = 1'b1;
        s_stb_i          = 1'b0;
        s_we_i           = 1'b0;
        s_addr_i         = '0;
        s_dat_i          = '0;
        m_send_dat_i     = '0;
        m_send_ack_i     = 1'b0;
        m_rcv_ack_i      = 1'b0;
        credit_i         = 1'b0;
        flit_i           = '0;
        flit_wr_i        = 1'b0;
        current_e_addr_i = MY_ADDR;
        credit_due       = 1'b0;
        hold             = 1'b0;
        outstanding      = 0;
        in_credits       = LB;
        send_wait        = 0;
        rcv_wait         = 0;
        errors           = 0;
        total_errors     = 0;
        tests            = 0;
        failed_tests     = 0;
        aborted          = 1'b0;
        test_name        = "";
        for (i = 0; i < 256; i++) begin
            mem[i] = 32'hdead0000 | i;    // every word tells its own index
        end
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        fd = $fopen("dv/ni_trace.txt", "r");
        assert (fd != 0) else abort_run("cannot open dv/ni_trace.txt");
        while (!aborted && !$feof(fd)) begin
            if ($fgets(line, fd) == 0) continue;
            if (line.len() < 2 || line.getc(0) == "#") continue;
            a = '0;
            b = '0;
            c = '0;
            n = $sscanf(line, "%c %h %h %h", cmd, a, b, c);
            case (cmd)
                "T": begin
                    close_test();
                    n = $sscanf(line, "%c %s", cmd, name);
                    test_name = name;
                end
                "W": reg_access(1'b1, a[3:0], b, rd);
                "R": begin
                    reg_access(1'b0, a[3:0], '0, rd);
                    check_value($sformatf("reg %0h", a), b, rd);
                end
                "P": begin
                    for (i = 0; i < c; i++) mem[8'(a + i)] = b + i;    // word address
                end
                "M": begin
                    for (i = 0; i < c; i++) begin
                        check_value($sformatf("mem %0h", a + 4 * i), b + i, mem[8'((a >> 2) + i)]);
                    end
                end
                "I": inject_packet(a, b, c);
                "S": expect_packet(a, b, c);
                "C": expect_held(a);
                "H": hold_credits();
                "U": hold = 1'b0;
                "Q": wait_irq();
                "K": begin
                    @(negedge clk);
                    check_value("irq_o", a, irq_o);
                    step_cycle();
                end
                default: abort_run($sformatf("trace line not understood: %s", line));
            endcase
        end
        if (fd != 0) $fclose(fd);
        close_test();

        $display("tests: %0d, failed: %0d, errors: %0d", tests, failed_tests, total_errors);
        if (total_errors == 0 && !aborted) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== hdl/ni_top.sv ====
`timescale 1ns/1ps
/* network interface top: register block, send and receive engines */
module ni_top
    import ni_pkg::*;
#(
    parameter int LB = 8
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      s_stb_i,
    input  logic      s_we_i,
    input  reg_addr_t s_addr_i,
    input  data_t     s_dat_i,
    output data_t     s_dat_o,
    output logic      s_ack_o,
    output logic      m_send_stb_o,
    output data_t     m_send_addr_o,
    input  data_t     m_send_dat_i,
    input  logic      m_send_ack_i,
    output logic      m_rcv_stb_o,
    output data_t     m_rcv_addr_o,
    output data_t     m_rcv_dat_o,
    input  logic      m_rcv_ack_i,
    output flit_t     flit_o,
    output logic      flit_wr_o,
    input  logic      credit_i,
    input  flit_t     flit_i,
    input  logic      flit_wr_i,
    output logic      credit_o,
    input  eaddr_t    current_e_addr_i,
    output logic      irq_o
);
    logic              send_start, send_busy, send_done, send_size_err;
    eaddr_t            send_dest;
    data_t             send_ptr;
    wsize_t            send_size;
    hdata_t            send_hdata;
    logic              rcv_start, rcv_busy, rcv_done, rcv_overflow;
    data_t             rcv_ptr;
    wsize_t            rcv_max;
    eaddr_t            rcv_src;
    hdata_t            rcv_hdata;
    logic [SIZE_W+1:0] rcv_size_bytes;

    ni_regs regs0 (
        .clk(clk), .reset(reset),
        .s_stb_i(s_stb_i), .s_we_i(s_we_i), .s_addr_i(s_addr_i), .s_dat_i(s_dat_i),
        .s_dat_o(s_dat_o), .s_ack_o(s_ack_o),
        .send_busy_i(send_busy), .send_done_i(send_done), .send_size_err_i(send_size_err),
        .rcv_busy_i(rcv_busy), .rcv_done_i(rcv_done), .rcv_overflow_i(rcv_overflow),
        .rcv_src_i(rcv_src), .rcv_hdata_i(rcv_hdata), .rcv_size_bytes_i(rcv_size_bytes),
        .send_start_o(send_start), .send_dest_o(send_dest), .send_ptr_o(send_ptr),
        .send_size_o(send_size), .send_hdata_o(send_hdata),
        .rcv_start_o(rcv_start), .rcv_ptr_o(rcv_ptr), .rcv_max_o(rcv_max),
        .irq_o(irq_o)
    );

    ni_send_dma #(.LB(LB)) send0 (
        .clk(clk), .reset(reset), .current_e_addr_i(current_e_addr_i),
        .send_start_i(send_start), .send_dest_i(send_dest), .send_ptr_i(send_ptr),
        .send_size_i(send_size), .send_hdata_i(send_hdata),
        .m_send_dat_i(m_send_dat_i), .m_send_ack_i(m_send_ack_i), .credit_i(credit_i),
        .m_send_stb_o(m_send_stb_o), .m_send_addr_o(m_send_addr_o),
        .flit_o(flit_o), .flit_wr_o(flit_wr_o),
        .send_busy_o(send_busy), .send_done_o(send_done), .send_size_err_o(send_size_err)
    );

    ni_receive_dma #(.LB(LB)) rcv0 (
        .clk(clk), .reset(reset), .flit_i(flit_i), .flit_wr_i(flit_wr_i),
        .rcv_start_i(rcv_start), .rcv_ptr_i(rcv_ptr), .rcv_max_i(rcv_max),
        .m_rcv_ack_i(m_rcv_ack_i), .credit_o(credit_o),
        .m_rcv_stb_o(m_rcv_stb_o), .m_rcv_addr_o(m_rcv_addr_o), .m_rcv_dat_o(m_rcv_dat_o),
        .rcv_busy_o(rcv_busy), .rcv_done_o(rcv_done), .rcv_overflow_o(rcv_overflow),
        .rcv_src_o(rcv_src), .rcv_hdata_o(rcv_hdata), .rcv_size_bytes_o(rcv_size_bytes)
    );

endmodule

// ==== hdl/ni_regs.sv ====
`timescale 1ns/1ps
/* wishbone slave register file, sticky status flags and interrupt */
module ni_regs
    import ni_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              s_stb_i,
    input  logic              s_we_i,
    input  reg_addr_t         s_addr_i,
    input  data_t             s_dat_i,
    output data_t             s_dat_o,
    output logic              s_ack_o,
    input  logic              send_busy_i,
    input  logic              send_done_i,
    input  logic              send_size_err_i,
    input  logic              rcv_busy_i,
    input  logic              rcv_done_i,
    input  logic              rcv_overflow_i,
    input  eaddr_t            rcv_src_i,
    input  hdata_t            rcv_hdata_i,
    input  logic [SIZE_W+1:0] rcv_size_bytes_i,
    output logic              send_start_o,
    output eaddr_t            send_dest_o,
    output data_t             send_ptr_o,
    output wsize_t            send_size_o,
    output hdata_t            send_hdata_o,
    output logic              rcv_start_o,
    output data_t             rcv_ptr_o,
    output wsize_t            rcv_max_o,
    output logic              irq_o
);
    logic       wr_en;
    logic [2:0] int_en;
    logic [2:0] sticky;     // sent, saved, any error
    logic       size_err;
    logic       ovf_err;
    data_t      ctrl_word;

    assign wr_en = s_stb_i && s_we_i && !s_ack_o;

    always_comb begin
        ctrl_word                   = '0;
        ctrl_word[CTRL_SEND_BUSY]   = send_busy_i;
        ctrl_word[CTRL_RCV_BUSY]    = rcv_busy_i;
        ctrl_word[CTRL_IEN +: 3]    = int_en;
        ctrl_word[CTRL_FLAG +: 3]   = sticky;
        ctrl_word[CTRL_SIZE_ERR]    = size_err;
        ctrl_word[CTRL_OVF_ERR]     = ovf_err;
    end

    // read mux, address is held until ack
    always_comb begin
        s_dat_o = '0;
        case (s_addr_i)
            REG_CTRL:       s_dat_o = ctrl_word;
            REG_SEND_DEST:  s_dat_o = data_t'(send_dest_o);
            REG_SEND_PTR:   s_dat_o = send_ptr_o;
            REG_SEND_SIZE:  s_dat_o = data_t'(send_size_o);
            REG_SEND_HDATA: s_dat_o = data_t'(send_hdata_o);
            REG_RCV_SRC:    s_dat_o = {rcv_hdata_i, 16'h0, 4'h0, rcv_src_i};
            REG_RCV_PTR:    s_dat_o = rcv_ptr_o;
            REG_RCV_SIZE:   s_dat_o = data_t'(rcv_size_bytes_i);
            REG_RCV_MAX:    s_dat_o = data_t'(rcv_max_o);
            REG_RCV_CTRL:   s_dat_o = data_t'(rcv_busy_i);
            default:        s_dat_o = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s_ack_o      <= 1'b0;
            send_start_o <= 1'b0;
            rcv_start_o  <= 1'b0;
            send_dest_o  <= '0;
            send_ptr_o   <= '0;
            send_size_o  <= '0;
            send_hdata_o <= '0;
            rcv_ptr_o    <= '0;
            rcv_max_o    <= '0;
        end else begin
            s_ack_o      <= s_stb_i && !s_ack_o;
            // starts follow the register update by one cycle
            send_start_o <= wr_en && (s_addr_i == REG_SEND_SIZE) && !send_busy_i;
            rcv_start_o  <= wr_en && (s_addr_i == REG_RCV_CTRL) && s_dat_i[0] && !rcv_busy_i;
            if (wr_en) begin
                case (s_addr_i)
                    REG_SEND_DEST:  send_dest_o  <= s_dat_i[EADDR_W-1:0];
                    REG_SEND_PTR:   send_ptr_o   <= s_dat_i;
                    REG_SEND_SIZE:  send_size_o  <= s_dat_i[SIZE_W-1:0];
                    REG_SEND_HDATA: send_hdata_o <= s_dat_i[HDATA_W-1:0];
                    REG_RCV_PTR:    rcv_ptr_o    <= s_dat_i;
                    REG_RCV_MAX:    rcv_max_o    <= s_dat_i[SIZE_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // sticky flags, write 1 to clear, a new event wins over the clear
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            int_en   <= '0;
            sticky   <= '0;
            size_err <= 1'b0;
            ovf_err  <= 1'b0;
        end else begin
            if (wr_en && s_addr_i == REG_CTRL) begin
                int_en   <= s_dat_i[CTRL_IEN +: 3];
                sticky   <= sticky & ~s_dat_i[CTRL_FLAG +: 3];
                size_err <= size_err & ~s_dat_i[CTRL_SIZE_ERR];
                ovf_err  <= ovf_err & ~s_dat_i[CTRL_OVF_ERR];
            end
            if (send_done_i) sticky[0] <= 1'b1;
            if (rcv_done_i) sticky[1] <= 1'b1;
            if (send_size_err_i || rcv_overflow_i) sticky[2] <= 1'b1;
            if (send_size_err_i) size_err <= 1'b1;
            if (rcv_overflow_i) ovf_err <= 1'b1;
        end
    end

    assign irq_o = |(sticky & int_en);

    a_ack_single: assert property (
        @(posedge clk) disable iff (reset) s_ack_o |=> !s_ack_o);

endmodule

// ==== hdl/ni_receive_dma.sv ====
`timescale 1ns/1ps
/* receive engine: flit FIFO, header capture and wishbone write master
   into the receive buffer */
module ni_receive_dma
    import ni_pkg::*;
#(
    parameter int LB = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  flit_t             flit_i,
    input  logic              flit_wr_i,
    input  logic              rcv_start_i,
    input  data_t             rcv_ptr_i,
    input  wsize_t            rcv_max_i,
    input  logic              m_rcv_ack_i,
    output logic              credit_o,
    output logic              m_rcv_stb_o,
    output data_t             m_rcv_addr_o,
    output data_t             m_rcv_dat_o,
    output logic              rcv_busy_o,
    output logic              rcv_done_o,
    output logic              rcv_overflow_o,
    output eaddr_t            rcv_src_o,
    output hdata_t            rcv_hdata_o,
    output logic [SIZE_W+1:0] rcv_size_bytes_o
);
    localparam int PTR_W = $clog2(LB);

    typedef enum logic [1:0] {R_IDLE, R_WAIT, R_DATA, R_DONE} rcv_state_t;

    flit_t        fifo_mem [LB];
    logic [PTR_W:0] wr_ptr;   // extra msb tells full from empty
    logic [PTR_W:0] rd_ptr;
    logic         fifo_empty;
    logic         fifo_full;
    logic         fifo_rd;
    flit_t        head;
    flit_flag_t   head_flag;
    rcv_state_t   state;
    wsize_t       word_cnt;   // payload words of the current packet
    logic         discard;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                        (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign head       = fifo_mem[rd_ptr[PTR_W-1:0]];
    assign head_flag  = flit_flag_t'(head[DATA_W +: 2]);

    always_ff @(posedge clk) begin
        if (flit_wr_i) begin
            fifo_mem[wr_ptr[PTR_W-1:0]] <= flit_i;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (flit_wr_i) wr_ptr <= wr_ptr + 1'b1;
            if (fifo_rd) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assign discard = (word_cnt >= rcv_max_i);   // buffer window is full

    always_comb begin
        fifo_rd = 1'b0;
        case (state)
            R_WAIT: fifo_rd = !fifo_empty;   // stray non-header flits are dropped
            R_DATA: fifo_rd = !fifo_empty && (discard || (m_rcv_stb_o && m_rcv_ack_i));
            default: fifo_rd = 1'b0;
        endcase
    end

    assign credit_o         = fifo_rd;
    assign rcv_overflow_o   = (state == R_DATA) && fifo_rd && (word_cnt == rcv_max_i);
    assign m_rcv_dat_o      = head[DATA_W-1:0];
    assign m_rcv_addr_o     = rcv_ptr_i + data_t'({word_cnt, 2'b00});
    assign rcv_size_bytes_o = {word_cnt, 2'b00};
    assign rcv_busy_o       = (state != R_IDLE);
    assign rcv_done_o       = (state == R_DONE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= R_IDLE;
            m_rcv_stb_o <= 1'b0;
            word_cnt    <= '0;
            rcv_src_o   <= '0;
            rcv_hdata_o <= '0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (rcv_start_i) state <= R_WAIT;
                end
                R_WAIT: begin
                    if (!fifo_empty && head_flag == HDR_FLIT) begin
                        state       <= R_DATA;
                        word_cnt    <= '0;
                        rcv_src_o   <= head[EADDR_W +: EADDR_W];
                        rcv_hdata_o <= head[2*EADDR_W +: HDATA_W];
                    end
                end
                R_DATA: begin
                    if (!m_rcv_stb_o) begin
                        if (!fifo_empty && !discard) m_rcv_stb_o <= 1'b1;
                    end else if (m_rcv_ack_i) begin
                        m_rcv_stb_o <= 1'b0;
                    end
                    if (fifo_rd) begin
                        word_cnt <= word_cnt + wsize_t'(1);   // discarded words count too
                        if (head_flag == TAIL_FLIT) state <= R_DONE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // the sender's credits must keep the FIFO from overrunning
    a_fifo_no_overrun: assert property (
        @(posedge clk) disable iff (reset) flit_wr_i |-> !fifo_full);

endmodule

// ==== hdl/ni_send_dma.sv ====
`timescale 1ns/1ps
/* send engine: wishbone read master, header/body/tail flit builder
   and credit counter toward the router */
module ni_send_dma
    import ni_pkg::*;
#(
    parameter int LB = 8
) (
    input  logic   clk,
    input  logic   reset,
    input  eaddr_t current_e_addr_i,
    input  logic   send_start_i,
    input  eaddr_t send_dest_i,
    input  data_t  send_ptr_i,
    input  wsize_t send_size_i,
    input  hdata_t send_hdata_i,
    input  data_t  m_send_dat_i,
    input  logic   m_send_ack_i,
    input  logic   credit_i,
    output logic   m_send_stb_o,
    output data_t  m_send_addr_o,
    output flit_t  flit_o,
    output logic   flit_wr_o,
    output logic   send_busy_o,
    output logic   send_done_o,
    output logic   send_size_err_o
);
    localparam int CRD_W = $clog2(LB + 1);

    typedef enum logic [1:0] {S_IDLE, S_HDR, S_READ, S_DONE} send_state_t;

    send_state_t      state;
    logic [CRD_W-1:0] credit_cnt;
    wsize_t           word_idx;
    wsize_t           size_q;     // size latched at start
    logic             have_credit;
    logic             last_word;
    data_t            hdr_payload;

    assign have_credit = (credit_cnt != '0);
    assign last_word   = (word_idx == size_q - wsize_t'(1));

    // dest at the low end, then source, then header datum
    assign hdr_payload = {{(DATA_W - 2*EADDR_W - HDATA_W){1'b0}},
                          send_hdata_i, current_e_addr_i, send_dest_i};

    // body and tail flits leave in the cycle of the memory ack
    assign flit_wr_o = ((state == S_HDR) && have_credit) || (m_send_stb_o && m_send_ack_i);

    always_comb begin
        if (state == S_HDR) begin
            flit_o = {HDR_FLIT, hdr_payload};
        end else if (last_word) begin
            flit_o = {TAIL_FLIT, m_send_dat_i};
        end else begin
            flit_o = {BODY_FLIT, m_send_dat_i};
        end
    end

    assign send_busy_o = (state != S_IDLE);
    assign send_done_o = (state == S_DONE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state           <= S_IDLE;
            m_send_stb_o    <= 1'b0;
            m_send_addr_o   <= '0;
            word_idx        <= '0;
            size_q          <= '0;
            send_size_err_o <= 1'b0;
        end else begin
            send_size_err_o <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (send_start_i) begin
                        if (send_size_i == '0) begin
                            send_size_err_o <= 1'b1;   // nothing to send
                        end else begin
                            state         <= S_HDR;
                            size_q        <= send_size_i;
                            word_idx      <= '0;
                            m_send_addr_o <= send_ptr_i;
                        end
                    end
                end
                S_HDR: begin
                    if (have_credit) begin
                        state <= S_READ;
                    end
                end
                S_READ: begin
                    if (!m_send_stb_o) begin
                        // a read only starts with a credit reserved for its flit
                        if (have_credit) begin
                            m_send_stb_o <= 1'b1;
                        end
                    end else if (m_send_ack_i) begin
                        m_send_stb_o  <= 1'b0;
                        word_idx      <= word_idx + wsize_t'(1);
                        m_send_addr_o <= m_send_addr_o + data_t'(4);
                        if (last_word) begin
                            state <= S_DONE;
                        end
                    end
                end
                default: state <= S_IDLE;   // done lasts one cycle
            endcase
        end
    end

    // credit counter, one per flit in flight at the router
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit_cnt <= CRD_W'(LB);
        end else if (flit_wr_o && !credit_i) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!flit_wr_o && credit_i) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    a_no_wr_without_credit: assert property (
        @(posedge clk) disable iff (reset) flit_wr_o |-> have_credit);

    // router never returns more credits than it took
    a_credit_bound: assert property (
        @(posedge clk) disable iff (reset) credit_cnt <= CRD_W'(LB));

endmodule

// ==== hdl/ni_pkg.sv ====
/* shared widths, flit and register types, register offsets and ctrl flag
   bit positions of the network interface */
package ni_pkg;

    localparam int DATA_W     = 32;
    localparam int EADDR_W    = 4;
    localparam int HDATA_W    = 8;
    localparam int SIZE_W     = 10;
    localparam int REG_ADDR_W = 4;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [EADDR_W-1:0]    eaddr_t;
    typedef logic [HDATA_W-1:0]    hdata_t;
    typedef logic [SIZE_W-1:0]     wsize_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [DATA_W+1:0]     flit_t;   // {flags, payload}

    typedef enum logic [1:0] {
        BODY_FLIT = 2'b00,
        TAIL_FLIT = 2'b01,
        HDR_FLIT  = 2'b10
    } flit_flag_t;

    localparam reg_addr_t REG_CTRL       = 4'd0;
    localparam reg_addr_t REG_SEND_DEST  = 4'd1;
    localparam reg_addr_t REG_SEND_PTR   = 4'd2;
    localparam reg_addr_t REG_SEND_SIZE  = 4'd3;
    localparam reg_addr_t REG_SEND_HDATA = 4'd4;
    localparam reg_addr_t REG_RCV_SRC    = 4'd8;
    localparam reg_addr_t REG_RCV_PTR    = 4'd9;
    localparam reg_addr_t REG_RCV_SIZE   = 4'd10;
    localparam reg_addr_t REG_RCV_MAX    = 4'd11;
    localparam reg_addr_t REG_RCV_CTRL   = 4'd13;

    // ctrl register layout
    localparam int CTRL_SEND_BUSY = 0;
    localparam int CTRL_RCV_BUSY  = 1;
    localparam int CTRL_IEN       = 2;   // 3 enables: sent, saved, error
    localparam int CTRL_FLAG      = 5;   // 3 sticky flags, same order
    localparam int CTRL_SIZE_ERR  = 8;
    localparam int CTRL_OVF_ERR   = 9;

endpackage
